// File: hdl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and instruction width
`define XLEN 16

// architectural registers
`define REG_COUNT 16

// data memory words, addressed by the low byte
`define DMEM_DEPTH 256

`endif

// File: hdl/cpuPkg.sv
package cpuPkg;

    // opcode field, instr[15:12]
    typedef enum logic [3:0] {
        OP_ADD  = 4'b0000,
        OP_GRT  = 4'b0001,
        OP_SUB  = 4'b0010,
        OP_EQ   = 4'b0011,
        OP_JALR = 4'b0100,
        OP_LUI  = 4'b0101,
        OP_JAL  = 4'b0110,
        OP_NOP7 = 4'b0111,
        OP_ADDI = 4'b1000,
        OP_LW   = 4'b1001,
        OP_SW   = 4'b1010,
        OP_BNE  = 4'b1011,
        OP_WRI  = 4'b1100,
        OP_REA  = 4'b1101,
        OP_NOPE = 4'b1110,
        OP_NOPF = 4'b1111
    } opcodeE;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } aluOpE;

    typedef enum logic [1:0] {
        IMM_S4    = 2'd0,
        IMM_NONE  = 2'd1,
        IMM_S8    = 2'd2,
        IMM_UPPER = 2'd3
    } immKindE;

    typedef enum logic {
        IN1_RS1 = 1'b0,
        IN1_PC  = 1'b1
    } in1SelE;

    typedef enum logic [1:0] {
        IN2_RS2 = 2'd0,
        IN2_ONE = 2'd1,
        IN2_IMM = 2'd2
    } in2SelE;

    typedef enum logic [1:0] {
        RES_SUM = 2'd0,
        RES_GRT = 2'd1,
        RES_EQ  = 2'd2
    } resSelE;

    typedef struct packed {
        immKindE immKind;
        aluOpE   aluOp;
        in1SelE  in1Sel;
        in2SelE  in2Sel;
        resSelE  resSel;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    jump;
        logic    branch;
        logic    ioWrite;
        logic    ioRead;
    } ctrlWordT;

endpackage

// File: hdl/ctrlBus.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

interface ctrlBus;
    import cpuPkg::*;

    // registered decode result, valid for the execute cycle
    ctrlWordT ctrl;
    logic     exec;

    // instruction fields captured with the control word
    logic [$clog2(`REG_COUNT)-1:0] rd;
    logic [$clog2(`REG_COUNT)-1:0] rs1;
    logic [$clog2(`REG_COUNT)-1:0] rs2;
    logic [7:0]                    imm8;

    modport cu (
        output ctrl, exec, rd, rs1, rs2, imm8
    );

    modport dp (
        input ctrl, exec, rd, rs1, rs2, imm8
    );

endinterface

// File: hdl/controlUnit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module controlUnit (
    input  logic             CLK,
    input  logic             rstN,
    input  logic [`XLEN-1:0] instr,
    ctrlBus.cu               bus
);
    import cpuPkg::*;

    // 0 = decode, 1 = execute
    logic     phase;
    opcodeE   opcode;
    ctrlWordT decoded;

    assign opcode = opcodeE'(instr[15:12]);

    always_comb
    begin
        decoded          = '0;
        decoded.immKind  = IMM_NONE;
        decoded.aluOp    = ALU_ADD;
        decoded.in1Sel   = IN1_RS1;
        decoded.in2Sel   = IN2_RS2;
        decoded.resSel   = RES_SUM;
        case (opcode)
            OP_ADD:
            begin
                decoded.regWrite = 1'b1;
            end
            OP_GRT:
            begin
                decoded.aluOp    = ALU_SUB;
                decoded.resSel   = RES_GRT;
                decoded.regWrite = 1'b1;
            end
            OP_SUB:
            begin
                decoded.aluOp    = ALU_SUB;
                decoded.regWrite = 1'b1;
            end
            OP_EQ:
            begin
                decoded.aluOp    = ALU_SUB;
                decoded.resSel   = RES_EQ;
                decoded.regWrite = 1'b1;
            end
            OP_JAL, OP_JALR:
            begin
                // alu gives the link value pc + 1
                decoded.immKind  = (opcode == OP_JAL) ? IMM_S8 : IMM_S4;
                decoded.in1Sel   = IN1_PC;
                decoded.in2Sel   = IN2_ONE;
                decoded.regWrite = 1'b1;
                decoded.jump     = 1'b1;
            end
            OP_LUI:
            begin
                decoded.immKind  = IMM_UPPER;
                decoded.in2Sel   = IN2_IMM;
                decoded.regWrite = 1'b1;
            end
            OP_ADDI, OP_LW:
            begin
                decoded.immKind  = IMM_S4;
                decoded.in2Sel   = IN2_IMM;
                decoded.regWrite = 1'b1;
                decoded.memRead  = (opcode == OP_LW);
            end
            OP_SW:
            begin
                decoded.immKind  = IMM_S4;
                decoded.in2Sel   = IN2_IMM;
                decoded.memWrite = 1'b1;
            end
            OP_BNE:
            begin
                // branch target formed in the alu
                decoded.immKind  = IMM_S4;
                decoded.in1Sel   = IN1_PC;
                decoded.in2Sel   = IN2_IMM;
                decoded.branch   = 1'b1;
            end
            OP_WRI:
            begin
                decoded.ioWrite  = 1'b1;
            end
            OP_REA:
            begin
                decoded.regWrite = 1'b1;
                decoded.ioRead   = 1'b1;
            end
            default:
            begin
                // unused opcodes fall through with all enables clear
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            phase    <= 1'b0;
            bus.ctrl <= '0;
        end
        else
        begin
            phase <= ~phase;
            if (!phase)
                bus.ctrl <= decoded;
        end
    end

    // instruction fields latched on the decode edge
    always_ff @(posedge CLK)
    begin
        if (!phase)
        begin
            bus.rd   <= instr[11:8];
            // lui reads register 0 as its base
            bus.rs1  <= (opcode == OP_LUI) ? '0 : instr[7:4];
            bus.rs2  <= instr[3:0];
            bus.imm8 <= instr[7:0];
        end
    end

    assign bus.exec = phase;

endmodule

// File: hdl/regFile.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module regFile (
    input  logic             CLK,
    ctrlBus.dp               bus,
    input  logic [`XLEN-1:0] wrData,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data,
    output logic [`XLEN-1:0] rdData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // register 0 is hardwired to zero
    function automatic logic [`XLEN-1:0] readReg(input logic [$clog2(`REG_COUNT)-1:0] idx);
        logic [`XLEN-1:0] value;
        value = (idx == '0) ? '0 : regs[idx];
        return value;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (bus.exec && bus.ctrl.regWrite && (bus.rd != '0))
            regs[bus.rd] <= wrData;
    end

    always_comb
    begin
        rs1Data = readReg(bus.rs1);
        rs2Data = readReg(bus.rs2);
        // third port feeds sw data and the bne compare
        rdData  = readReg(bus.rd);
    end

endmodule

// File: hdl/immGen.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module immGen (
    ctrlBus.dp               bus,
    output logic [`XLEN-1:0] imm
);
    import cpuPkg::*;

    always_comb
    begin
        case (bus.ctrl.immKind)
            IMM_S4:
            begin
                // imm4 lives in the rs2 field
                imm = {{(`XLEN-4){bus.rs2[3]}}, bus.rs2};
            end
            IMM_S8:
            begin
                imm = {{(`XLEN-8){bus.imm8[7]}}, bus.imm8};
            end
            IMM_UPPER:
            begin
                imm = {bus.imm8, {(`XLEN-8){1'b0}}};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module aluUnit (
    ctrlBus.dp               bus,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] aluResult
);
    import cpuPkg::*;

    logic [`XLEN-1:0] in1;
    logic [`XLEN-1:0] in2;
    logic [`XLEN:0]   sumExt;
    logic [`XLEN-1:0] sum;
    logic             borrow;
    logic             isZero;

    assign in1 = (bus.ctrl.in1Sel == IN1_PC) ? pc : rs1Data;

    always_comb
    begin
        case (bus.ctrl.in2Sel)
            IN2_ONE: in2 = {{(`XLEN-1){1'b0}}, 1'b1};
            IN2_IMM: in2 = imm;
            default: in2 = rs2Data;
        endcase
    end

    // one extra bit keeps the borrow of a subtract
    assign sumExt = (bus.ctrl.aluOp == ALU_SUB) ? ({1'b0, in1} - {1'b0, in2})
                                                : ({1'b0, in1} + {1'b0, in2});
    assign sum    = sumExt[`XLEN-1:0];
    assign borrow = sumExt[`XLEN];
    assign isZero = (sum == '0);

    // unsigned in1 > in2: no borrow and nonzero difference
    always_comb
    begin
        case (bus.ctrl.resSel)
            RES_GRT: aluResult = {{(`XLEN-1){1'b0}}, ~borrow & ~isZero};
            RES_EQ:  aluResult = {{(`XLEN-1){1'b0}}, isZero};
            default: aluResult = sum;
        endcase
    end

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module pcUnit (
    input  logic             CLK,
    input  logic             rstN,
    ctrlBus.dp               bus,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rdData,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] pc
);
    import cpuPkg::*;

    logic [`XLEN-1:0] pcPlusOne;
    logic [`XLEN-1:0] jumpBase;
    logic [`XLEN-1:0] jumpTarget;
    logic [`XLEN-1:0] pcNext;
    logic             taken;

    assign pcPlusOne = pc + 1'b1;

    // jalr carries the 4-bit immediate and jumps from rs1, jal from pc
    assign jumpBase   = (bus.ctrl.immKind == IMM_S4) ? rs1Data : pc;
    assign jumpTarget = jumpBase + imm;

    // alu already holds pc + imm for bne
    assign taken = bus.ctrl.branch && (rdData != rs1Data);

    always_comb
    begin
        if (bus.ctrl.jump)
            pcNext = jumpTarget;
        else if (taken)
            pcNext = aluResult;
        else
            pcNext = pcPlusOne;
    end

    always_ff @(posedge CLK)
    begin
        if (!rstN)
            pc <= '0;
        else if (bus.exec)
            pc <= pcNext;
    end

endmodule

// File: hdl/dataMem.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module dataMem (
    input  logic                           CLK,
    ctrlBus.dp                             bus,
    input  logic [$clog2(`DMEM_DEPTH)-1:0] addr,
    input  logic [`XLEN-1:0]               wrData,
    output logic [`XLEN-1:0]               memData
);

    logic [`XLEN-1:0] mem [`DMEM_DEPTH];

    // store lands on the execute edge
    always_ff @(posedge CLK)
    begin
        if (bus.exec && bus.ctrl.memWrite)
            mem[addr] <= wrData;
    end

    // read is combinational so lw writes back in the same execute cycle
    assign memData = mem[addr];

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpuTop (
    input  logic             CLK,
    input  logic             rstN,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] ioIn,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] ioOut,
    output logic             ioStrobe
);

    ctrlBus bus ();

    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] rdData;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] memData;
    logic [`XLEN-1:0] wrData;

    controlUnit uCtrl (
        .CLK   (CLK),
        .rstN  (rstN),
        .instr (instr),
        .bus   (bus.cu)
    );

    regFile uRegs (
        .CLK     (CLK),
        .bus     (bus.dp),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rdData  (rdData)
    );

    immGen uImm (
        .bus (bus.dp),
        .imm (imm)
    );

    aluUnit uAlu (
        .bus       (bus.dp),
        .pc        (pc),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .aluResult (aluResult)
    );

    pcUnit uPc (
        .CLK       (CLK),
        .rstN      (rstN),
        .bus       (bus.dp),
        .rs1Data   (rs1Data),
        .rdData    (rdData),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc)
    );

    // address wraps to the low byte of the sum
    dataMem uDmem (
        .CLK     (CLK),
        .bus     (bus.dp),
        .addr    (aluResult[$clog2(`DMEM_DEPTH)-1:0]),
        .wrData  (rdData),
        .memData (memData)
    );

    // write-back source
    always_comb
    begin
        if (bus.ctrl.memRead)
            wrData = memData;
        else if (bus.ctrl.ioRead)
            wrData = ioIn;
        else
            wrData = aluResult;
    end

    // output port, strobe follows a wri execute edge for one cycle
    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            ioOut    <= '0;
            ioStrobe <= 1'b0;
        end
        else
        begin
            ioStrobe <= bus.exec && bus.ctrl.ioWrite;
            if (bus.exec && bus.ctrl.ioWrite)
                ioOut <= rs1Data;
        end
    end

endmodule

// File: tb/cpuTb.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_INSTR    = 2000;
    // two cycles per instruction plus reset and some slack
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_INSTR * 2 + 20) * CLK_PERIOD;

    logic             CLK;
    logic             rstN;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] ioIn;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] ioOut;
    logic             ioStrobe;

    // instruction memory, indexed by the low byte of pc
    logic [`XLEN-1:0] imem [256];

    // ISA model state
    logic [`XLEN-1:0] mRegs [`REG_COUNT];
    logic [`XLEN-1:0] mMem [`DMEM_DEPTH];
    logic [`XLEN-1:0] mPc;
    logic [`XLEN-1:0] mIoOut;
    logic             mStrobe;

    integer seed;
    int     errors;
    int     checks;

    cpuTop u_dut (
        .CLK      (CLK),
        .rstN     (rstN),
        .instr    (instr),
        .ioIn     (ioIn),
        .pc       (pc),
        .ioOut    (ioOut),
        .ioStrobe (ioStrobe)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic checkValue(input string name, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s expected 0x%04h actual 0x%04h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic checkStrobe(input logic expected);
        checks++;
        if (expected && ioStrobe !== 1'b1)
        begin
            errors++;
            $display("Output strobe missing after a wri at %0t", $time);
        end
        else if (!expected && ioStrobe !== 1'b0)
        begin
            errors++;
            $display("Output strobe raised when no wri executed at %0t", $time);
        end
    endtask

    function automatic logic [`XLEN-1:0] modelReg(input logic [3:0] idx);
        return (idx == 4'd0) ? '0 : mRegs[idx];
    endfunction

    // prologue fills memory and registers, the rest is random
    task automatic buildProgram();
        logic [`XLEN-1:0] word;
        imem[0] = {OP_LUI, 4'd3, 8'h01};
        imem[1] = {OP_LUI, 4'd1, 8'h00};
        // loop: mem[r1] = r1 for every address
        imem[2] = {OP_SW, 4'd1, 4'd1, 4'd0};
        imem[3] = {OP_ADDI, 4'd1, 4'd1, 4'd1};
        imem[4] = {OP_BNE, 4'd3, 4'd1, 4'hE};
        for (int k = 1; k < 16; k++)
            imem[4 + k] = {OP_LUI, 4'(k), 8'($random(seed))};
        for (int i = 20; i < 256; i++)
        begin
            word = 16'($random(seed));
            // zero offsets would spin on one address forever
            if (word[15:12] == OP_JAL && word[7:0] == 8'd0)
                word[7:0] = 8'd1;
            if (word[15:12] == OP_BNE && word[3:0] == 4'd0)
                word[3:0] = 4'd1;
            imem[i] = word;
        end
    endtask

    // one instruction of the reference model, ioSample is ioIn at the execute edge
    task automatic stepModel(input logic [`XLEN-1:0] ioSample);
        logic [`XLEN-1:0] ir;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] d;
        logic [`XLEN-1:0] imm4s;
        logic [`XLEN-1:0] imm8s;
        logic [`XLEN-1:0] addrSum;
        logic [`XLEN-1:0] nextPc;
        logic [`XLEN-1:0] wrVal;
        logic [3:0]       rd;
        opcodeE           op;
        logic             wrEn;
        ir      = imem[mPc[7:0]];
        op      = opcodeE'(ir[15:12]);
        rd      = ir[11:8];
        a       = modelReg(ir[7:4]);
        b       = modelReg(ir[3:0]);
        d       = modelReg(rd);
        imm4s   = {{12{ir[3]}}, ir[3:0]};
        imm8s   = {{8{ir[7]}}, ir[7:0]};
        addrSum = a + imm4s;
        nextPc  = mPc + 16'd1;
        mStrobe = 1'b0;
        case (op)
            OP_ADD:          wrVal = a + b;
            OP_SUB:          wrVal = a - b;
            OP_GRT:          wrVal = (a > b) ? 16'd1 : 16'd0;
            OP_EQ:           wrVal = (a == b) ? 16'd1 : 16'd0;
            OP_ADDI:         wrVal = addrSum;
            OP_LUI:          wrVal = {ir[7:0], 8'd0};
            OP_JAL, OP_JALR: wrVal = mPc + 16'd1;
            OP_LW:           wrVal = mMem[addrSum[7:0]];
            OP_REA:          wrVal = ioSample;
            default:         wrVal = 16'd0;
        endcase
        wrEn = !(op inside {OP_SW, OP_BNE, OP_WRI, OP_NOP7, OP_NOPE, OP_NOPF});
        if (op == OP_JAL)
            nextPc = mPc + imm8s;
        else if (op == OP_JALR)
            nextPc = a + imm4s;
        else if (op == OP_BNE && d != a)
            nextPc = mPc + imm4s;
        if (op == OP_SW)
            mMem[addrSum[7:0]] = d;
        if (op == OP_WRI)
        begin
            mIoOut  = a;
            mStrobe = 1'b1;
        end
        if (wrEn && rd != 4'd0)
            mRegs[rd] = wrVal;
        mPc = nextPc;
    endtask

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        CLK    = 1'b0;
        rstN   = 1'b0;
        instr  = '0;
        ioIn   = '0;
        seed   = 67;
        errors = 0;
        checks = 0;
        mPc    = '0;
        mIoOut = '0;
        mStrobe = 1'b0;
        foreach (mRegs[i])
            mRegs[i] = '0;
        foreach (mMem[i])
            mMem[i] = '0;
        buildProgram();

        repeat (RESET_CYCLES) @(negedge CLK);
        checkValue("pc", 16'd0, pc);
        checkValue("ioOut", 16'd0, ioOut);
        checkStrobe(1'b0);
        rstN = 1'b1;

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            // decode cycle
            instr = imem[pc[7:0]];
            ioIn  = 16'($random(seed));
            @(negedge CLK);
            // execute cycle, pc holds until the closing edge
            checkValue("pc", mPc, pc);
            checkStrobe(1'b0);
            instr = imem[pc[7:0]];
            ioIn  = 16'($random(seed));
            stepModel(ioIn);
            @(negedge CLK);
            checkValue("pc", mPc, pc);
            checkValue("ioOut", mIoOut, ioOut);
            checkStrobe(mStrobe);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/ctrlBus.sv
hdl/controlUnit.sv
hdl/regFile.sv
hdl/immGen.sv
hdl/aluUnit.sv
hdl/pcUnit.sv
hdl/dataMem.sv
hdl/cpuTop.sv
tb/cpuTb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cpuTb simulation with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module cpuTb -f verilog.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"
exit 0
